/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_top_tb \
    -f soc_top.f -o soc_top_sim \
    && ./obj_dir/soc_top_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log && exit 0 || exit 1

/* soc_top.f */
source/soc_pkg.sv
source/bus_arbiter.sv
source/mem_decode.sv
source/ram.sv
source/sys_regs.sv
source/uart_tx.sv
source/soc_top.sv
verif/soc_top_tb.sv

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
    import soc_pkg::*;
(
    input  logic     pll_clk,
    input  logic     reset,
    input  mem_req_t instr_req,
    input  mem_req_t data_req,
    input  mem_rsp_t mem_rsp,
    output mem_rsp_t instr_rsp,
    output mem_rsp_t data_rsp,
    output mem_req_t mem_req
);

    arb_state_e state;

    logic instr_pending;
    logic data_pending;

    // the instruction port only ever reads.
    assign instr_pending = instr_req.read;
    assign data_pending = data_req.read || data_req.write;

    // data port wins a tie.
    always_ff @(posedge pll_clk) begin
        if (reset) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    if (data_pending) begin
                        state <= arb_data;
                    end else if (instr_pending) begin
                        state <= arb_instr;
                    end
                end
                arb_instr, arb_data: begin
                    if (mem_rsp.ready) begin
                        state <= arb_idle;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    always_comb begin
        mem_req = '0;
        case (state)
            arb_instr: begin
                mem_req.address = instr_req.address;
                mem_req.read = instr_req.read;
            end
            arb_data: begin
                mem_req = data_req;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // read data goes to both, ready only to the owner.
    always_comb begin
        instr_rsp.read_value = mem_rsp.read_value;
        instr_rsp.ready = mem_rsp.ready && (state == arb_instr);
        data_rsp.read_value = mem_rsp.read_value;
        data_rsp.ready = mem_rsp.ready && (state == arb_data);
    end

    // the owner keeps its strobe until the bus answers.
    owner_holds_request: assert property (
        @(posedge pll_clk) disable iff (reset)
        (state != arb_idle) |-> ((state == arb_instr) ? instr_pending : data_pending)
    );

endmodule

/* source/mem_decode.sv */
`timescale 1ns/1ps

module mem_decode
    import soc_pkg::*;
(
    input  logic        pll_clk,
    input  logic        reset,
    input  mem_req_t    mem_req,
    input  logic [31:0] ram_read_value,
    input  logic [31:0] leds_read_value,
    input  logic [31:0] uart_read_value,
    input  logic [31:0] timer_read_value,
    input  logic        ram_ready,
    input  logic        regs_ready,
    input  logic        uart_ready,
    output logic        ram_sel,
    output logic        regs_sel,
    output logic        uart_sel,
    output mem_rsp_t    mem_rsp
);

    region_e region;
    region_e region_q;
    logic    none_ready;

    always_comb begin
        if ((mem_req.address & ram_mask) == ram_base) begin
            region = region_ram;
        end else if ((mem_req.address & leds_mask) == leds_base) begin
            region = region_leds;
        end else if ((mem_req.address & uart_mask) == uart_base) begin
            region = region_uart;
        end else if ((mem_req.address & timer_mask) == timer_base) begin
            region = region_timer;
        end else begin
            region = region_none;
        end
    end

    assign ram_sel = (region == region_ram);
    assign regs_sel = (region == region_leds) || (region == region_timer);
    assign uart_sel = (region == region_uart);

    // unmapped accesses answer themselves after one cycle.
    always_ff @(posedge pll_clk) begin
        if (reset) begin
            region_q <= region_none;
            none_ready <= 1'b0;
        end else begin
            region_q <= region;
            none_ready <= (region == region_none) && (mem_req.read || mem_req.write)
                          && !none_ready;
        end
    end

    always_comb begin
        case (region_q)
            region_ram:   mem_rsp = '{read_value: ram_read_value, ready: ram_ready};
            region_leds:  mem_rsp = '{read_value: leds_read_value, ready: regs_ready};
            region_uart:  mem_rsp = '{read_value: uart_read_value, ready: uart_ready};
            region_timer: mem_rsp = '{read_value: timer_read_value, ready: regs_ready};
            default:      mem_rsp = '{read_value: 32'h0, ready: none_ready};
        endcase
    end

    // regions answer one at a time.
    one_ready: assert property (
        @(posedge pll_clk) disable iff (reset)
        $onehot0({ram_ready, regs_ready, uart_ready, none_ready})
    );

endmodule

/* source/ram.sv */
`timescale 1ns/1ps

module ram
    import soc_pkg::*;
(
    input  logic        pll_clk,
    input  logic        reset,
    input  logic        sel,
    input  mem_req_t    mem_req,
    output logic [31:0] read_value,
    output logic        ready
);

    logic [31:0] words [ram_words];

    logic [ram_addr_width-1:0] index;
    logic                      access;

    // aliases within the region.
    assign index = mem_req.address[ram_addr_width+1:2];

    // no second access on the completing cycle.
    assign access = sel && (mem_req.read || mem_req.write) && !ready;

    always_ff @(posedge pll_clk) begin
        if (access && mem_req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req.write_mask[i]) begin
                    words[index][8*i +: 8] <= mem_req.write_value[8*i +: 8];
                end
            end
        end
        if (access) begin
            read_value <= words[index];
        end
    end

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= access;
        end
    end

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

    // address map, one base and mask pair per region.
    localparam logic [31:0] ram_base = 32'h0000_0000;
    localparam logic [31:0] ram_mask = 32'hffff_0000;

    localparam logic [31:0] leds_base = 32'h0001_0000;
    localparam logic [31:0] leds_mask = 32'hffff_fffc;

    localparam logic [31:0] uart_base = 32'h0002_0000;
    localparam logic [31:0] uart_mask = 32'hffff_fff0;

    localparam logic [31:0] timer_base = 32'h0003_0000;
    localparam logic [31:0] timer_mask = 32'hffff_fff0;

    // word offsets within a register region, from address bits 3:2.
    localparam logic [1:0] uart_data_offset = 2'd0;
    localparam logic [1:0] uart_status_offset = 2'd1;
    localparam logic [1:0] timer_low_offset = 2'd0;
    localparam logic [1:0] timer_high_offset = 2'd1;

    localparam int ram_words = 1024;
    localparam int ram_addr_width = $clog2(ram_words);

    // short bit time for simulation.
    localparam int clocks_per_bit = 16;
    localparam int baud_width = $clog2(clocks_per_bit);
    localparam logic [baud_width-1:0] baud_last = baud_width'(clocks_per_bit - 1);

    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [3:0]  write_mask;
        logic [31:0] write_value;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] read_value;
        logic        ready;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        region_ram,
        region_leds,
        region_uart,
        region_timer,
        region_none
    } region_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_instr,
        arb_data
    } arb_state_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

endpackage

/* source/soc_top.sv */
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic       pll_clk,
    input  logic       reset,
    input  mem_req_t   instr_req,
    output mem_rsp_t   instr_rsp,
    input  mem_req_t   data_req,
    output mem_rsp_t   data_rsp,
    output logic [7:0] leds,
    output logic       uart_tx
);

    // common bus.
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    logic ram_sel;
    logic regs_sel;
    logic uart_sel;

    logic [31:0] ram_read_value;
    logic [31:0] regs_read_value;
    logic [31:0] uart_read_value;

    logic ram_ready;
    logic regs_ready;
    logic uart_ready;

    bus_arbiter bus_arbiter_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .instr_req(instr_req),
        .data_req(data_req),
        .mem_rsp(mem_rsp),
        .instr_rsp(instr_rsp),
        .data_rsp(data_rsp),
        .mem_req(mem_req)
    );

    // leds and timer share one register block.
    mem_decode mem_decode_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .mem_req(mem_req),
        .ram_read_value(ram_read_value),
        .leds_read_value(regs_read_value),
        .uart_read_value(uart_read_value),
        .timer_read_value(regs_read_value),
        .ram_ready(ram_ready),
        .regs_ready(regs_ready),
        .uart_ready(uart_ready),
        .ram_sel(ram_sel),
        .regs_sel(regs_sel),
        .uart_sel(uart_sel),
        .mem_rsp(mem_rsp)
    );

    ram ram_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .sel(ram_sel),
        .mem_req(mem_req),
        .read_value(ram_read_value),
        .ready(ram_ready)
    );

    sys_regs sys_regs_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .sel(regs_sel),
        .mem_req(mem_req),
        .leds(leds),
        .read_value(regs_read_value),
        .ready(regs_ready)
    );

    uart_tx uart_tx_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .sel(uart_sel),
        .mem_req(mem_req),
        .uart_tx(uart_tx),
        .read_value(uart_read_value),
        .ready(uart_ready)
    );

endmodule

/* source/sys_regs.sv */
`timescale 1ns/1ps

module sys_regs
    import soc_pkg::*;
(
    input  logic        pll_clk,
    input  logic        reset,
    input  logic        sel,
    input  mem_req_t    mem_req,
    output logic [7:0]  leds,
    output logic [31:0] read_value,
    output logic        ready
);

    logic [63:0] cycle;
    logic [31:0] cycle_high_shadow;
    logic [1:0]  offset;
    logic        is_timer;
    logic        access;

    assign offset = mem_req.address[3:2];
    assign is_timer = (mem_req.address & timer_mask) == timer_base;
    assign access = sel && (mem_req.read || mem_req.write) && !ready;

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            cycle <= 64'h0;
            leds <= 8'h0;
            ready <= 1'b0;
        end else begin
            cycle <= cycle + 64'h1;
            ready <= access;
            if (access && mem_req.write && !is_timer && mem_req.write_mask[0]) begin
                leds <= mem_req.write_value[7:0];
            end
        end
    end

    // low read latches the high half for the next read.
    always_ff @(posedge pll_clk) begin
        if (access) begin
            if (!is_timer) begin
                read_value <= {24'h0, leds};
            end else if (offset == timer_low_offset) begin
                read_value <= cycle[31:0];
                cycle_high_shadow <= cycle[63:32];
            end else if (offset == timer_high_offset) begin
                read_value <= cycle_high_shadow;
            end else begin
                read_value <= 32'h0;
            end
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
    import soc_pkg::*;
(
    input  logic        pll_clk,
    input  logic        reset,
    input  logic        sel,
    input  mem_req_t    mem_req,
    output logic        uart_tx,
    output logic [31:0] read_value,
    output logic        ready
);

    tx_state_e state;

    logic [7:0]            shift;
    logic [2:0]            bit_cnt;
    logic [baud_width-1:0] baud_cnt;
    logic [1:0]            offset;
    logic                  busy;
    logic                  data_write;
    logic                  access;
    logic                  load;
    logic                  bit_done;

    assign offset = mem_req.address[3:2];
    assign busy = (state != tx_idle);
    assign data_write = mem_req.write && (offset == uart_data_offset);
    // data writes wait for the line to go idle.
    assign access = sel && (mem_req.read || mem_req.write) && !ready && !(data_write && busy);
    assign load = access && data_write && mem_req.write_mask[0];
    assign bit_done = (baud_cnt == baud_last);

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            state <= tx_idle;
            uart_tx <= 1'b1;
            ready <= 1'b0;
            baud_cnt <= '0;
            bit_cnt <= 3'd0;
        end else begin
            ready <= access;
            baud_cnt <= (state == tx_idle || bit_done) ? '0 : baud_cnt + 1'b1;
            case (state)
                tx_idle: begin
                    if (load) begin
                        state <= tx_start;
                        uart_tx <= 1'b0;
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        state <= tx_data;
                        bit_cnt <= 3'd0;
                        uart_tx <= shift[0];
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= tx_stop;
                            uart_tx <= 1'b1;
                        end else begin
                            uart_tx <= shift[1];
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge pll_clk) begin
        if (load) begin
            shift <= mem_req.write_value[7:0];
        end else if (state == tx_data && bit_done) begin
            shift <= {1'b0, shift[7:1]};
        end
        if (access) begin
            read_value <= (offset == uart_status_offset) ? {31'h0, busy} : 32'h0;
        end
    end

    idle_line_high: assert property (
        @(posedge pll_clk) disable iff (reset)
        (state == tx_idle) |-> uart_tx
    );

endmodule

/* verif/soc_top_tb.sv */
`timescale 1ns/1ps

module soc_top_tb
    import soc_pkg::*;
();

    localparam int timeout_cycles = 1000;
    localparam int pool_size = 16;

    logic       pll_clk;
    logic       reset;
    mem_req_t   instr_req;
    mem_rsp_t   instr_rsp;
    mem_req_t   data_req;
    mem_rsp_t   data_rsp;
    logic [7:0] leds;
    logic       uart_tx;

    int check_errors = 0;
    int other_errors = 0;

    // reference model.
    logic [31:0] model_ram [ram_words];
    logic [7:0]  model_leds;
    int          pool [pool_size];
    logic [7:0]  uart_sent [$];
    logic [7:0]  uart_seen [$];

    soc_top soc_top_inst (
        .pll_clk(pll_clk),
        .reset(reset),
        .instr_req(instr_req),
        .instr_rsp(instr_rsp),
        .data_req(data_req),
        .data_rsp(data_rsp),
        .leds(leds),
        .uart_tx(uart_tx)
    );

    initial begin
        pll_clk = 1'b0;
        forever #10 pll_clk = ~pll_clk;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            check_errors++;
        end
    endtask

    // random bits 15:12 exercise the aliasing.
    function automatic logic [31:0] ram_address(input int index);
        return {16'h0, 4'($urandom), 10'(index), 2'b00};
    endfunction

    // entered 2 ns after a rising edge, and left at the same point.
    task automatic data_access(input logic [31:0] addr, input logic is_write,
                               input logic [3:0] mask, input logic [31:0] value,
                               output logic [31:0] read_value);
        int waited;
        data_req.address = addr;
        data_req.read = !is_write;
        data_req.write = is_write;
        data_req.write_mask = mask;
        data_req.write_value = value;
        waited = 0;
        do begin
            @(negedge pll_clk);
            waited++;
        end while (!data_rsp.ready && waited < timeout_cycles);
        if (!data_rsp.ready) begin
            $display("data port timed out waiting for ready at address %h", addr);
            other_errors++;
        end
        read_value = data_rsp.read_value;
        @(posedge pll_clk);
        #2;
        data_req = '0;
    endtask

    task automatic instr_access(input logic [31:0] addr, output logic [31:0] read_value);
        int waited;
        instr_req = '0;
        instr_req.address = addr;
        instr_req.read = 1'b1;
        waited = 0;
        do begin
            @(negedge pll_clk);
            waited++;
        end while (!instr_rsp.ready && waited < timeout_cycles);
        if (!instr_rsp.ready) begin
            $display("instruction port timed out waiting for ready at address %h", addr);
            other_errors++;
        end
        read_value = instr_rsp.read_value;
        @(posedge pll_clk);
        #2;
        instr_req = '0;
    endtask

    always @(negedge pll_clk) begin
        if (!reset) begin
            compare_value("instr_rsp.ready with data_rsp.ready", 1'b0,
                          instr_rsp.ready && data_rsp.ready);
        end
    end

    // line sampled on falling clock edges, mid-bit is half a bit time in.
    initial begin : uart_monitor
        int         phase;
        logic       active;
        logic [7:0] bits;
        active = 1'b0;
        phase = 0;
        bits = 8'h0;
        forever begin
            @(negedge pll_clk);
            if (reset) begin
                active = 1'b0;
            end else if (!active) begin
                if (!uart_tx) begin
                    active = 1'b1;
                    phase = 0;
                end
            end else begin
                phase++;
                if (phase % clocks_per_bit == clocks_per_bit / 2) begin
                    if (phase < clocks_per_bit) begin
                        if (uart_tx) begin
                            $display("uart start bit went high before mid-bit");
                            other_errors++;
                            active = 1'b0;
                        end
                    end else if (phase < 9 * clocks_per_bit) begin
                        bits[phase / clocks_per_bit - 1] = uart_tx;
                    end else begin
                        if (!uart_tx) begin
                            $display("uart stop bit was low");
                            other_errors++;
                        end
                        uart_seen.push_back(bits);
                        active = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : main
        logic [31:0] value;
        logic [31:0] rd;
        logic [31:0] fetched;
        logic [31:0] address;
        logic [31:0] low_word;
        logic [63:0] first_count;
        logic [63:0] second_count;
        logic [3:0]  mask;
        int          index;
        int          waited;

        void'($urandom(32'hbb211a83));
        reset = 1'b1;
        instr_req = '0;
        data_req = '0;
        repeat (3) @(posedge pll_clk);
        #2;
        reset = 1'b0;
        compare_value("instr_rsp.ready", 1'b0, instr_rsp.ready);
        compare_value("data_rsp.ready", 1'b0, data_rsp.ready);
        compare_value("leds", 8'h0, leds);
        compare_value("uart_tx", 1'b1, uart_tx);

        // every pool word gets one full write first.
        for (int i = 0; i < pool_size; i++) begin
            pool[i] = $urandom_range(511);
            value = $urandom;
            data_access(ram_address(pool[i]), 1'b1, 4'hf, value, rd);
            model_ram[pool[i]] = value;
        end
        for (int i = 0; i < 32; i++) begin
            index = pool[$urandom_range(pool_size - 1)];
            mask = 4'($urandom);
            value = $urandom;
            data_access(ram_address(index), 1'b1, mask, value, rd);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    model_ram[index][8*b +: 8] = value[8*b +: 8];
                end
            end
        end
        for (int i = 0; i < pool_size; i++) begin
            data_access(ram_address(pool[i]), 1'b0, 4'h0, 32'h0, rd);
            compare_value("data_rsp.read_value", model_ram[pool[i]], rd);
        end

        // data traffic stays in the upper half, away from the pool.
        fork
            begin
                for (int i = 0; i < pool_size; i++) begin
                    instr_access(ram_address(pool[i]), fetched);
                    compare_value("instr_rsp.read_value", model_ram[pool[i]], fetched);
                end
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    index = 512 + $urandom_range(511);
                    value = $urandom;
                    data_access(ram_address(index), 1'b1, 4'hf, value, rd);
                    model_ram[index] = value;
                    data_access(ram_address(index), 1'b0, 4'h0, 32'h0, rd);
                    compare_value("data_rsp.read_value", model_ram[index], rd);
                end
            end
        join

        model_leds = 8'h0;
        for (int i = 0; i < 10; i++) begin
            mask = 4'($urandom);
            value = $urandom;
            data_access(leds_base, 1'b1, mask, value, rd);
            if (mask[0]) begin
                model_leds = value[7:0];
            end
            compare_value("leds", model_leds, leds);
            data_access(leds_base, 1'b0, 4'h0, 32'h0, rd);
            compare_value("leds read_value", {24'h0, model_leds}, rd);
        end

        // later writes stall until the previous frame is out.
        for (int i = 0; i < 4; i++) begin
            value = $urandom;
            uart_sent.push_back(value[7:0]);
            data_access(uart_base, 1'b1, 4'h1, value, rd);
            data_access(uart_base + 32'h4, 1'b0, 4'h0, 32'h0, rd);
            compare_value("uart status busy", 1'b1, rd[0]);
        end
        waited = 0;
        do begin
            @(posedge pll_clk);
            waited++;
        end while (uart_seen.size() < uart_sent.size() && waited < 20 * clocks_per_bit);
        #2;
        if (uart_seen.size() != uart_sent.size()) begin
            $display("uart monitor received %0d of %0d bytes",
                     uart_seen.size(), uart_sent.size());
            other_errors++;
        end
        for (int i = 0; i < uart_sent.size(); i++) begin
            if (i < uart_seen.size()) begin
                compare_value("uart byte", uart_sent[i], uart_seen[i]);
            end
        end
        repeat (10 * clocks_per_bit) @(posedge pll_clk);
        #2;
        data_access(uart_base + 32'h4, 1'b0, 4'h0, 32'h0, rd);
        compare_value("uart status busy", 1'b0, rd[0]);

        data_access(timer_base, 1'b0, 4'h0, 32'h0, low_word);
        data_access(timer_base + 32'h4, 1'b0, 4'h0, 32'h0, value);
        first_count = {value, low_word};
        data_access(timer_base, 1'b0, 4'h0, 32'h0, low_word);
        data_access(timer_base + 32'h4, 1'b0, 4'h0, 32'h0, value);
        second_count = {value, low_word};
        compare_value("cycle counter increases", 1'b1, second_count > first_count);

        for (int i = 0; i < 12; i++) begin
            case (i)
                0: address = leds_base + 32'h4;
                1: address = uart_base + 32'h10;
                2: address = timer_base + 32'h10;
                default: address = {16'($urandom_range(16'hffff, 16'h0004)),
                                    14'($urandom), 2'b00};
            endcase
            data_access(address, 1'b0, 4'h0, 32'h0, rd);
            compare_value("unmapped read_value", 32'h0, rd);
        end

        $display("errors: %0d check, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
